/* row_sum_pkg.sv */
package row_sum_pkg;

    // matrix geometry
    localparam int ROWS      = 10;
    localparam int COLS      = 8;

    // widths
    localparam int VAL_W     = 4;
    localparam int SUM_W     = 7;   // holds 8 x 15 = 120
    localparam int ROW_IDX_W = 4;

    // one unsigned matrix value
    typedef logic [VAL_W-1:0] val_t;

    // column 0 sits in the top nibble
    typedef val_t [0:COLS-1] row_t;

    // row 0 sits in the top 32 bits
    typedef row_t [0:ROWS-1] matrix_t;

    // adder tree level widths
    typedef logic [VAL_W:0]   pair_t;   // first level
    typedef logic [VAL_W+1:0] quad_t;   // second level
    typedef logic [SUM_W-1:0] sum_t;    // full row

    typedef logic [ROW_IDX_W-1:0] row_idx_t;

endpackage

/* row_sequencer.sv */
`timescale 1ns/1ns

module row_sequencer
    import row_sum_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  logic     sum_valid,
    output row_idx_t row_idx,
    output logic     row_issue,
    output logic     done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT_DRAIN
    } state_t;

    state_t   state;
    row_idx_t sum_cnt;    // sums returned this pass
    logic     done_q;
    logic     last_sum;
    logic     last_row;

    assign row_issue = (state == ST_ISSUE);
    assign last_row  = (row_idx == row_idx_t'(ROWS - 1));

    // tenth strobe coming back from the tree
    assign last_sum  = (state == ST_WAIT_DRAIN) && sum_valid &&
                       (sum_cnt == row_idx_t'(ROWS - 1));

    // rises in the same cycle as the last sum, held by done_q after that
    assign done      = done_q || last_sum;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            row_idx <= '0;
            sum_cnt <= '0;
            done_q  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin    // also taken while done is up
                        state   <= ST_ISSUE;
                        row_idx <= '0;
                        sum_cnt <= '0;
                        done_q  <= 1'b0;
                    end
                end
                ST_ISSUE: begin
                    if (last_row) begin
                        state <= ST_WAIT_DRAIN;
                    end else begin
                        row_idx <= row_idx + 1'b1;
                    end
                    if (sum_valid) begin    // early rows already out of the tree
                        sum_cnt <= sum_cnt + 1'b1;
                    end
                end
                ST_WAIT_DRAIN: begin
                    if (sum_valid) begin
                        sum_cnt <= sum_cnt + 1'b1;
                    end
                    if (last_sum) begin
                        state  <= ST_IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    a_done_not_issuing: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(done && row_issue)
    );

    // tree output only while a pass is open
    a_sum_only_in_pass: assert property (
        @(posedge clk) disable iff (!rst_n)
        sum_valid |-> (state != ST_IDLE)
    );

endmodule

/* row_fetch.sv */
`timescale 1ns/1ns

module row_fetch
    import row_sum_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  matrix_t  matrix,
    input  row_idx_t row_idx,
    input  logic     row_issue,
    output row_t     lane_vals,
    output logic     lane_valid
);

    row_t row_sel;

    // row select mux, no padding for unused codes
    always_comb begin
        row_sel = '0;
        for (int r = 0; r < ROWS; r++) begin
            if (row_idx == row_idx_t'(r)) begin
                row_sel = matrix[r];
            end
        end
    end

    // input register rank, one nibble per lane
    always_ff @(posedge clk) begin
        if (row_issue) begin
            lane_vals <= row_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lane_valid <= 1'b0;
        end else begin
            lane_valid <= row_issue;
        end
    end

    a_row_idx_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        row_issue |-> (row_idx < row_idx_t'(ROWS))
    );

endmodule

/* pair_add_stage.sv */
`timescale 1ns/1ns

module pair_add_stage
    import row_sum_pkg::*;
#(
    parameter int  LANES = COLS,
    parameter type in_t  = val_t,
    parameter type out_t = pair_t
) (
    input  logic               clk,
    input  logic               rst_n,
    input  in_t  [0:LANES-1]   in_vals,
    input  logic               in_valid,
    output out_t [0:LANES/2-1] out_vals,
    output logic               out_valid
);

    out_t [0:LANES/2-1] pair_sum;

    // lane 2i plus lane 2i+1, widened first so the carry is kept
    for (genvar i = 0; i < LANES / 2; i++) begin : g_pair
        assign pair_sum[i] = out_t'(in_vals[2*i]) + out_t'(in_vals[2*i+1]);
    end

    always_ff @(posedge clk) begin
        out_vals <= pair_sum;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;    // tracks data one level down
        end
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid)
    );

endmodule

/* row_sum_top.sv */
`timescale 1ns/1ns

module row_sum_top
    import row_sum_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  matrix_t matrix,
    output sum_t    sum,
    output logic    sum_valid,
    output logic    done
);

    row_idx_t       row_idx;
    logic           row_issue;

    row_t           lane_vals;
    logic           lane_valid;

    pair_t [0:3]    pair_vals;
    logic           pair_valid;

    quad_t [0:1]    quad_vals;
    logic           quad_valid;

    row_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .sum_valid (sum_valid),
        .row_idx   (row_idx),
        .row_issue (row_issue),
        .done      (done)
    );

    row_fetch u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .matrix     (matrix),
        .row_idx    (row_idx),
        .row_issue  (row_issue),
        .lane_vals  (lane_vals),
        .lane_valid (lane_valid)
    );

    // 8 nibbles to 4 pair sums
    pair_add_stage #(
        .LANES (COLS),
        .in_t  (val_t),
        .out_t (pair_t)
    ) u_add_l1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_vals   (lane_vals),
        .in_valid  (lane_valid),
        .out_vals  (pair_vals),
        .out_valid (pair_valid)
    );

    pair_add_stage #(
        .LANES (COLS / 2),
        .in_t  (pair_t),
        .out_t (quad_t)
    ) u_add_l2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_vals   (pair_vals),
        .in_valid  (pair_valid),
        .out_vals  (quad_vals),
        .out_valid (quad_valid)
    );

    // single lane left, that is the row sum
    pair_add_stage #(
        .LANES (COLS / 4),
        .in_t  (quad_t),
        .out_t (sum_t)
    ) u_add_l3 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_vals   (quad_vals),
        .in_valid  (quad_valid),
        .out_vals  (sum),
        .out_valid (sum_valid)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;    // released just after the edge, like the other inputs
        rst_n = 1'b1;
    end

endmodule

/* tb_row_sum.sv */
`timescale 1ns/1ns

module tb_row_sum
    import row_sum_pkg::*;
();

    localparam int RESET_CYCLES   = 10;
    localparam int DRIVE_DELAY    = 2;
    localparam int LATENCY        = 4;     // start edge to first sum
    localparam int IDLE_CHECKS    = 3;     // done must hold after a pass
    localparam int RAND_PASSES    = 2;
    localparam int MAX_TESTS      = 8;
    localparam int WORDS_PER_TEST = 1 + ROWS;
    localparam int GOLDEN_WORDS   = 1 + MAX_TESTS * WORDS_PER_TEST;
    localparam int MAT_W          = ROWS * COLS * VAL_W;

    logic    clk;
    logic    rst_n;
    logic    start;
    matrix_t matrix;
    sum_t    sum;
    logic    sum_valid;
    logic    done;

    logic [MAT_W-1:0] golden [0:GOLDEN_WORDS-1];
    sum_t             exp_sums [0:ROWS-1];
    logic [31:0]      rng;
    int               n_tests;
    int               passes_run;
    int               cycles = 0;
    int               cycle_limit = 0;

    tb_clock_gen #(
        .HALF_PERIOD  (4),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    row_sum_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .matrix    (matrix),
        .sum       (sum),
        .sum_valid (sum_valid),
        .done      (done)
    );

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic tick();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_sum(input sum_t got, input sum_t exp, input string name);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // row 0 in the top 32 bits, column 0 in the top nibble of its row
    function automatic sum_t row_total(input logic [MAT_W-1:0] flat, input int r);
        int acc;
        acc = 0;
        for (int c = 0; c < COLS; c++) begin
            acc += int'(flat[MAT_W-1 - (r*COLS + c)*VAL_W -: VAL_W]);
        end
        return sum_t'(acc);
    endfunction

    task automatic run_pass(input logic [MAT_W-1:0] m, input bit extra_start);
        logic exp_valid;
        logic exp_done;
        tick();
        check_flag(done, passes_run > 0, "done before start");
        check_flag(sum_valid, 1'b0, "sum_valid before start");
        matrix = matrix_t'(m);
        start  = 1'b1;
        for (int cyc = 0; cyc < LATENCY + ROWS + IDLE_CHECKS; cyc++) begin
            tick();
            start     = extra_start && (cyc == 1 || cyc == ROWS);    // issue, then drain
            exp_valid = (cyc >= LATENCY) && (cyc < LATENCY + ROWS);
            exp_done  = (cyc >= LATENCY + ROWS - 1);
            check_flag(sum_valid, exp_valid, "sum_valid");
            check_flag(done, exp_done, "done");
            if (exp_valid) begin
                check_sum(sum, exp_sums[cyc - LATENCY],
                          $sformatf("sum of row %0d", cyc - LATENCY));
            end
        end
        passes_run++;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            abort_run();
        end
    end

    initial begin
        logic [MAT_W-1:0] rand_mat;
        int               base;
        start      = 1'b0;
        matrix     = '0;
        rng        = 32'hb81f8579;
        passes_run = 0;
        $readmemh("row_sum_golden.txt", golden);
        n_tests = int'(golden[0][31:0]);
        if (n_tests < 1 || n_tests > MAX_TESTS) begin
            $display("golden file gives %0d tests, expected 1 to %0d", n_tests, MAX_TESTS);
            abort_run();
        end
        cycle_limit = 20 * (n_tests + RAND_PASSES) + RESET_CYCLES;

        wait (rst_n === 1'b1);
        repeat (4) begin    // quiet until the first start
            tick();
            check_flag(sum_valid, 1'b0, "sum_valid after reset");
            check_flag(done, 1'b0, "done after reset");
        end

        for (int t = 0; t < n_tests; t++) begin
            base = 1 + t * WORDS_PER_TEST;
            for (int r = 0; r < ROWS; r++) begin
                exp_sums[r] = golden[base + 1 + r][SUM_W-1:0];
                if (exp_sums[r] !== row_total(golden[base], r)) begin
                    $display("golden test %0d row %0d: listed sum does not match its matrix",
                             t, r);
                    abort_run();
                end
            end
            run_pass(golden[base], t == n_tests - 1);
        end

        for (int p = 0; p < RAND_PASSES; p++) begin
            for (int r = 0; r < ROWS; r++) begin
                rng = xorshift32(rng);
                rand_mat[MAT_W-1 - r*COLS*VAL_W -: COLS*VAL_W] = rng;
            end
            for (int r = 0; r < ROWS; r++) begin
                exp_sums[r] = row_total(rand_mat, r);
            end
            run_pass(rand_mat, p == RAND_PASSES - 1);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

/* row_sum_golden.txt */
// word 0: number of tests
// per test: matrix word (row 0 first, column 0 leftmost), then the 10 row sums
4
00000000_11111111_22222222_33333333_44444444_55555555_66666666_77777777_88888888_99999999
00
08
10
18
20
28
30
38
40
48
FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF
78
78
78
78
78
78
78
78
78
78
01234567_89ABCDEF_01234567_89ABCDEF_01234567_89ABCDEF_01234567_89ABCDEF_01234567_89ABCDEF
1C
5C
1C
5C
1C
5C
1C
5C
1C
5C
F0000000_0000000F_12345678_FEDCBA98_80808080_0F0F0F0F_A5A50000_13579BDF_02468ACE_DEADBEEF
0F
0F
24
5C
20
3C
1E
40
38
68

/* flist.f */
row_sum_pkg.sv
row_sequencer.sv
row_fetch.sv
pair_add_stage.sv
row_sum_top.sv
tb_clock_gen.sv
tb_row_sum.sv

/* Makefile */
TOP := tb_row_sum

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
